/* source/i2c_init_pkg.sv */
// Shared widths, table entry type, FSM and opcode enums, and the entry decoder for the I2C init design
`default_nettype none

package i2c_init_pkg;

    // table entry and bus widths
    localparam int ENTRY_W    = 9;
    localparam int I2C_ADDR_W = 7;
    localparam int DATA_W     = 8;

    // init table size
    localparam int ROM_LEN = 13;
    localparam int ROM_AW  = $clog2(ROM_LEN);

    // entry FIFO, depth kept a power of two so the pointers wrap on their own
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // a delay entry with field d waits 2**(DELAY_BASE + d) cycles
    localparam int DELAY_BASE = 4;
    localparam int DELAY_W    = 24;

    typedef logic [ENTRY_W-1:0] init_entry_t;

    typedef enum logic [2:0] {
        OP_HALT,
        OP_START,
        OP_WRITE,
        OP_DELAY,
        OP_STOP,
        OP_INVALID
    } entry_op_e;

    typedef enum logic {
        RD_IDLE,
        RD_FETCH
    } reader_state_e;

    typedef enum logic [1:0] {
        IS_IDLE,
        IS_RUN,
        IS_DELAY
    } issuer_state_e;

    // entry encodings
    //   1 dddddddd  write data
    //   01 aaaaaaa  start write to address
    //   00001 dddd  delay
    //   001000001   send stop
    //   000000000   halt
    function automatic entry_op_e decode_entry(input init_entry_t e);
        if (e[8]) begin
            return OP_WRITE;
        end else if (e[8:7] == 2'b01) begin
            return OP_START;
        end else if (e[8:4] == 5'b00001) begin
            return OP_DELAY;
        end else if (e == 9'b001000001) begin
            return OP_STOP;
        end else if (e == 9'd0) begin
            return OP_HALT;
        end
        // includes the old multi-device codes
        return OP_INVALID;
    endfunction

endpackage

`default_nettype wire

/* source/init_table_reader.sv */
// Init table ROM and fetch FSM; after each start it pushes table entries into the entry FIFO
`timescale 1ns/1ps
`default_nettype none

module init_table_reader (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      full,
    output logic                      push,
    output i2c_init_pkg::init_entry_t push_entry,
    output logic                      fetch_active
);

    i2c_init_pkg::reader_state_e         state;
    logic                                start_flag;
    logic [i2c_init_pkg::ROM_AW-1:0]     index;
    i2c_init_pkg::init_entry_t           rom_word;

    // init sequence
    always_comb begin
        case (index)
            0:       rom_word = {2'b01, 7'h50};
            1:       rom_word = {1'b1, 8'h00};
            2:       rom_word = {1'b1, 8'h04};
            3:       rom_word = {1'b1, 8'h11};
            4:       rom_word = {1'b1, 8'h22};
            // former exit-mode code, skipped by the issuer
            5:       rom_word = 9'b000000001;
            6:       rom_word = {5'b00001, 4'd1};
            7:       rom_word = {1'b1, 8'h33};
            8:       rom_word = {1'b1, 8'h44};
            9:       rom_word = 9'b001000001;
            10:      rom_word = {2'b01, 7'h51};
            11:      rom_word = {1'b1, 8'hAA};
            // halt at the end and past it
            default: rom_word = '0;
        endcase
    end

    assign fetch_active = (state == i2c_init_pkg::RD_FETCH);
    assign push         = fetch_active && !full;
    assign push_entry   = rom_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= i2c_init_pkg::RD_IDLE;
            start_flag <= 1'b0;
            index      <= '0;
        end else begin
            case (state)
                i2c_init_pkg::RD_IDLE: begin
                    // start edge only counts once the flag has rearmed
                    if (start && !start_flag) begin
                        state      <= i2c_init_pkg::RD_FETCH;
                        start_flag <= 1'b1;
                        index      <= '0;
                    end
                end
                i2c_init_pkg::RD_FETCH: begin
                    if (push) begin
                        index <= index + 1'b1;
                        if (i2c_init_pkg::decode_entry(rom_word) == i2c_init_pkg::OP_HALT) begin
                            state <= i2c_init_pkg::RD_IDLE;
                        end
                    end
                end
                default: state <= i2c_init_pkg::RD_IDLE;
            endcase

            // rearm once start is seen low
            if (!start) begin
                start_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/init_entry_fifo.sv */
// Small synchronous FIFO between the table reader and the command issuer, head shown first-word-fall-through
`timescale 1ns/1ps
`default_nettype none

module init_entry_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  i2c_init_pkg::init_entry_t push_entry,
    input  logic                      pop,
    output i2c_init_pkg::init_entry_t pop_entry,
    output logic                      full,
    output logic                      empty
);

    i2c_init_pkg::init_entry_t          mem [i2c_init_pkg::FIFO_DEPTH];
    logic [i2c_init_pkg::FIFO_AW-1:0]   wr_ptr;
    logic [i2c_init_pkg::FIFO_AW-1:0]   rd_ptr;
    logic [i2c_init_pkg::FIFO_AW:0]     count;
    logic                               do_push;
    logic                               do_pop;

    assign full      = (count == i2c_init_pkg::FIFO_DEPTH);
    assign empty     = (count == 0);
    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign pop_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/init_cmd_issuer.sv */
// Decodes FIFO entries into I2C master commands and transmit bytes, runs delays and reports busy
`timescale 1ns/1ps
`default_nettype none

module init_cmd_issuer (
    input  logic                                clk,
    input  logic                                rst,
    input  i2c_init_pkg::init_entry_t           pop_entry,
    input  logic                                empty,
    output logic                                pop,
    input  logic                                fetch_active,
    output logic [i2c_init_pkg::I2C_ADDR_W-1:0] cmd_address,
    output logic                                cmd_start,
    output logic                                cmd_write,
    output logic                                cmd_stop,
    output logic                                cmd_valid,
    input  logic                                cmd_ready,
    output logic [i2c_init_pkg::DATA_W-1:0]     tx_data,
    output logic                                tx_valid,
    input  logic                                tx_ready,
    output logic                                busy
);

    i2c_init_pkg::issuer_state_e        state;
    i2c_init_pkg::entry_op_e            op;
    logic [i2c_init_pkg::DELAY_W-1:0]   delay_cnt;
    logic [i2c_init_pkg::DELAY_W-1:0]   delay_load;
    logic                               cmd_xfer;

    assign op       = i2c_init_pkg::decode_entry(pop_entry);
    assign cmd_xfer = cmd_valid && cmd_ready;

    // head entry is consumed only with both output registers free
    assign pop = (state == i2c_init_pkg::IS_RUN) && !empty && !cmd_valid && !tx_valid;

    // counter loads 2**(DELAY_BASE + d) - 1 and runs down to zero inclusive
    assign delay_load = {i2c_init_pkg::DELAY_W{1'b1}}
        >> (i2c_init_pkg::DELAY_W - i2c_init_pkg::DELAY_BASE - pop_entry[3:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= i2c_init_pkg::IS_IDLE;
            delay_cnt <= '0;
            cmd_start <= 1'b0;
            cmd_write <= 1'b0;
            cmd_stop  <= 1'b0;
            cmd_valid <= 1'b0;
            tx_valid  <= 1'b0;
            busy      <= 1'b0;
        end else begin
            // command bits drop once their command has gone out
            if (cmd_xfer) begin
                cmd_start <= 1'b0;
                cmd_write <= 1'b0;
                cmd_stop  <= 1'b0;
                cmd_valid <= 1'b0;
            end
            if (tx_valid && tx_ready) begin
                tx_valid <= 1'b0;
            end

            case (state)
                i2c_init_pkg::IS_IDLE: begin
                    if (!empty) begin
                        state <= i2c_init_pkg::IS_RUN;
                    end
                end
                i2c_init_pkg::IS_RUN: begin
                    if (pop) begin
                        case (op)
                            i2c_init_pkg::OP_START: begin
                                // start rides on the next command
                                cmd_address <= pop_entry[i2c_init_pkg::I2C_ADDR_W-1:0];
                                cmd_start   <= 1'b1;
                            end
                            i2c_init_pkg::OP_WRITE: begin
                                cmd_write <= 1'b1;
                                cmd_stop  <= 1'b0;
                                cmd_valid <= 1'b1;
                                tx_data   <= pop_entry[i2c_init_pkg::DATA_W-1:0];
                                tx_valid  <= 1'b1;
                            end
                            i2c_init_pkg::OP_DELAY: begin
                                delay_cnt <= delay_load;
                                state     <= i2c_init_pkg::IS_DELAY;
                            end
                            i2c_init_pkg::OP_STOP: begin
                                cmd_start <= 1'b0;
                                cmd_write <= 1'b0;
                                cmd_stop  <= 1'b1;
                                cmd_valid <= 1'b1;
                            end
                            i2c_init_pkg::OP_HALT: begin
                                // final stop closes the sequence
                                cmd_start <= 1'b0;
                                cmd_write <= 1'b0;
                                cmd_stop  <= 1'b1;
                                cmd_valid <= 1'b1;
                                state     <= i2c_init_pkg::IS_IDLE;
                            end
                            default: begin
                                // invalid entries are dropped
                            end
                        endcase
                    end
                end
                i2c_init_pkg::IS_DELAY: begin
                    if (delay_cnt == 0) begin
                        state <= i2c_init_pkg::IS_RUN;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                default: state <= i2c_init_pkg::IS_IDLE;
            endcase

            // final stop still waiting for cmd_ready counts as activity
            busy <= fetch_active || !empty || (state != i2c_init_pkg::IS_IDLE)
                || cmd_valid;
        end
    end

endmodule

`default_nettype wire

/* source/i2c_init.sv */
// Top level of the boot-time I2C initializer; connects table reader, entry FIFO and command issuer
`timescale 1ns/1ps
`default_nettype none

module i2c_init (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    output logic [i2c_init_pkg::I2C_ADDR_W-1:0] cmd_address,
    output logic                                cmd_start,
    output logic                                cmd_write,
    output logic                                cmd_stop,
    output logic                                cmd_valid,
    input  logic                                cmd_ready,
    output logic [i2c_init_pkg::DATA_W-1:0]     tx_data,
    output logic                                tx_valid,
    input  logic                                tx_ready,
    output logic                                busy
);

    logic                       push;
    logic                       pop;
    logic                       full;
    logic                       empty;
    logic                       fetch_active;
    i2c_init_pkg::init_entry_t  push_entry;
    i2c_init_pkg::init_entry_t  pop_entry;

    init_table_reader u_reader (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .full         (full),
        .push         (push),
        .push_entry   (push_entry),
        .fetch_active (fetch_active)
    );

    init_entry_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .pop_entry  (pop_entry),
        .full       (full),
        .empty      (empty)
    );

    init_cmd_issuer u_issuer (
        .clk          (clk),
        .rst          (rst),
        .pop_entry    (pop_entry),
        .empty        (empty),
        .pop          (pop),
        .fetch_active (fetch_active),
        .cmd_address  (cmd_address),
        .cmd_start    (cmd_start),
        .cmd_write    (cmd_write),
        .cmd_stop     (cmd_stop),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .busy         (busy)
    );

endmodule

`default_nettype wire

/* test/i2c_init_props.sv */
// Handshake and reset assertions for the I2C initializer, bound into its top level
`timescale 1ns/1ps
`default_nettype none

module i2c_init_props (
    input logic                                clk,
    input logic                                rst,
    input logic                                cmd_valid,
    input logic                                cmd_ready,
    input logic [i2c_init_pkg::I2C_ADDR_W-1:0] cmd_address,
    input logic                                tx_valid,
    input logic                                tx_ready,
    input logic [i2c_init_pkg::DATA_W-1:0]     tx_data,
    input logic                                busy
);

    // a valid holds its data until the sink takes it
    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_address))
        else $error("cmd_valid dropped or cmd_address changed before cmd_ready");

    tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else $error("tx_valid dropped or tx_data changed before tx_ready");

    reset_clears: assert property (@(posedge clk) rst |=> !cmd_valid && !tx_valid && !busy)
        else $error("outputs not cleared by reset");

endmodule

bind i2c_init i2c_init_props u_props (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_address (cmd_address),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready),
    .tx_data     (tx_data),
    .busy        (busy)
);

`default_nettype wire

/* test/tb_i2c_init.sv */
// Testbench for the I2C initializer; runs the init table three times and checks every transfer
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_init;

    logic                                clk = 1'b0;
    logic                                rst = 1'b1;
    logic                                start = 1'b0;
    logic                                cmd_ready = 1'b1;
    logic                                tx_ready = 1'b1;
    logic [i2c_init_pkg::I2C_ADDR_W-1:0] cmd_address;
    logic                                cmd_start;
    logic                                cmd_write;
    logic                                cmd_stop;
    logic                                cmd_valid;
    logic [i2c_init_pkg::DATA_W-1:0]     tx_data;
    logic                                tx_valid;
    logic                                busy;

    // reference copy of the init table
    i2c_init_pkg::init_entry_t init_table [i2c_init_pkg::ROM_LEN] = '{
        9'h0D0, 9'h100, 9'h104, 9'h111, 9'h122, 9'h001, 9'h011,
        9'h133, 9'h144, 9'h041, 9'h0D1, 9'h1AA, 9'h000
    };

    // expected command is {address, start, write, stop}
    logic [i2c_init_pkg::I2C_ADDR_W+2:0] exp_cmd [$];
    logic [i2c_init_pkg::I2C_ADDR_W+2:0] exp_c;
    logic [i2c_init_pkg::DATA_W-1:0]     exp_tx [$];
    logic [31:0]                         rng_state = 32'hcb99_38ad;
    logic                                random_ready = 1'b0;
    logic                                run_done = 1'b0;
    logic                                in_run = 1'b0;
    logic                                wait_33 = 1'b0;
    int                                  cycle_count = 0;
    int                                  byte22_cycle = 0;
    int                                  write_count = 0;
    int                                  tx_count = 0;

    i2c_init DUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic end_with_failure(input string reason);
        if (reason != "") begin
            $display("%s", reason);
        end
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string signal, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", signal, got, exp);
        end_with_failure("");
    endtask

    task automatic check_cmd(
        input logic [i2c_init_pkg::I2C_ADDR_W-1:0] got_address,
        input logic got_start, got_write, got_stop,
        input logic [i2c_init_pkg::I2C_ADDR_W-1:0] exp_address,
        input logic exp_start, exp_write, exp_stop
    );
        if (got_address !== exp_address) begin
            report_mismatch("cmd_address", got_address, exp_address);
        end
        if (got_start !== exp_start) begin
            report_mismatch("cmd_start", got_start, exp_start);
        end
        if (got_write !== exp_write) begin
            report_mismatch("cmd_write", got_write, exp_write);
        end
        if (got_stop !== exp_stop) begin
            report_mismatch("cmd_stop", got_stop, exp_stop);
        end
    endtask

    task automatic check_tx(input logic [i2c_init_pkg::DATA_W-1:0] got,
                            input logic [i2c_init_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            report_mismatch("tx_data", got, exp);
        end
    endtask

    // expand the table by the entry rules into expected transfers
    task automatic build_expected();
        logic [i2c_init_pkg::I2C_ADDR_W-1:0] addr;
        logic                                pending_start;
        logic                                halted;
        addr = '0;
        pending_start = 1'b0;
        halted = 1'b0;
        exp_cmd.delete();
        exp_tx.delete();
        for (int i = 0; i < i2c_init_pkg::ROM_LEN; i++) begin
            if (!halted) begin
                casez (init_table[i])
                    9'b1????????: begin
                        exp_cmd.push_back({addr, pending_start, 1'b1, 1'b0});
                        exp_tx.push_back(init_table[i][7:0]);
                        pending_start = 1'b0;
                    end
                    9'b01???????: begin
                        addr = init_table[i][6:0];
                        pending_start = 1'b1;
                    end
                    9'b001000001: begin
                        exp_cmd.push_back({addr, 3'b001});
                        pending_start = 1'b0;
                    end
                    9'b000000000: begin
                        exp_cmd.push_back({addr, 3'b001});
                        halted = 1'b1;
                    end
                    // delays and invalid codes give no transfer
                    default: ;
                endcase
            end
        end
    endtask

    // ready back-pressure, about three cycles in four
    always @(posedge clk) begin
        rng_state <= next_random(rng_state);
        if (random_ready) begin
            cmd_ready <= (rng_state[3:2] != 2'b00);
            tx_ready  <= (rng_state[9:8] != 2'b00);
        end else begin
            cmd_ready <= 1'b1;
            tx_ready  <= 1'b1;
        end
    end

    // transfer monitor, sampled mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            cycle_count++;
            if (cmd_valid && cmd_ready) begin
                if (exp_cmd.size() == 0) begin
                    end_with_failure("command transfer when none was expected");
                end else begin
                    exp_c = exp_cmd.pop_front();
                    check_cmd(cmd_address, cmd_start, cmd_write, cmd_stop,
                              exp_c[i2c_init_pkg::I2C_ADDR_W+2:3], exp_c[2], exp_c[1], exp_c[0]);
                    if (cmd_write) begin
                        write_count++;
                    end
                    run_done = (exp_cmd.size() == 0);
                end
            end
            if (tx_valid && tx_ready) begin
                if (exp_tx.size() == 0) begin
                    end_with_failure("transmit transfer when none was expected");
                end else begin
                    check_tx(tx_data, exp_tx.pop_front());
                    tx_count++;
                    if (tx_data == 8'h22) begin
                        byte22_cycle = cycle_count;
                        wait_33 = 1'b1;
                    end
                end
            end
            if (wait_33 && tx_valid && tx_data == 8'h33) begin
                if (cycle_count - byte22_cycle < (1 << (i2c_init_pkg::DELAY_BASE + 1))) begin
                    end_with_failure("delay entry was shorter than its programmed length");
                end
                wait_33 = 1'b0;
            end
            if (write_count > tx_count + 1 || tx_count > write_count + 1) begin
                end_with_failure("write commands and transmit bytes got out of step");
            end
            if (in_run && !run_done && !busy) begin
                end_with_failure("busy dropped in the middle of a sequence");
            end
        end
    end

    task automatic wait_busy(input logic value, input int limit, input string what);
        int n;
        n = 0;
        while (busy !== value && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (busy !== value) begin
            end_with_failure(what);
        end
    endtask

    task automatic wait_run_done(input int limit);
        int n;
        n = 0;
        while (!run_done && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!run_done) begin
            end_with_failure("sequence did not finish in time");
        end
    endtask

    task automatic run_sequence(input logic hold_start, input logic back_pressure);
        build_expected();
        run_done = 1'b0;
        @(posedge clk);
        random_ready <= back_pressure;
        start <= 1'b1;
        if (!hold_start) begin
            @(posedge clk);
            start <= 1'b0;
        end
        wait_busy(1'b1, 10, "busy did not rise after start");
        in_run = 1'b1;
        wait_run_done(4000);
        // halt stop has just transferred
        wait_busy(1'b0, 2, "busy stayed high after the final stop");
        in_run = 1'b0;
        if (exp_tx.size() != 0 || write_count != tx_count) begin
            end_with_failure("transmit bytes were missing at the end of a sequence");
        end
    endtask

    task automatic check_idle_window(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            if (cmd_valid || tx_valid || busy) begin
                end_with_failure("a second sequence started while start stayed high");
            end
        end
    endtask

    initial begin
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        if (cmd_valid || tx_valid || busy) begin
            end_with_failure("outputs were not low after reset");
        end
        // single pulse, then held start, then rearm after one low cycle
        run_sequence(1'b0, 1'b0);
        run_sequence(1'b1, 1'b1);
        check_idle_window(60);
        start <= 1'b0;
        run_sequence(1'b1, 1'b1);
        if (exp_cmd.size() == 0 && exp_tx.size() == 0 && write_count == 21) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "transfer count differs from the model");
        end
    end

endmodule

`default_nettype wire

/* project.f */
source/i2c_init_pkg.sv
source/init_table_reader.sv
source/init_entry_fifo.sv
source/init_cmd_issuer.sv
source/i2c_init.sv
test/i2c_init_props.sv
test/tb_i2c_init.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the I2C initializer testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f project.f --top-module tb_i2c_init -o sim_i2c_init \
    || { echo "build failed"; exit 1; }

# a crash or an assertion stop also counts as failure
(./obj_dir/sim_i2c_init || echo "Simulation finished: FAIL") 2>&1 | tee sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "result: FAIL"; exit 1; } \
    || { echo "result: PASS"; exit 0; }
